/* rv_pkg.sv */
// rv32i execute stage types
package rv_pkg;

    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  reg_idx_t;  // register index
    typedef logic [3:0]  byte_sel_t; // bit n selects byte lane n

    typedef enum logic [2:0] {
        cls_alu,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_load,
        cls_store,
        cls_none
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_lui,
        alu_auipc
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word
    } mem_size_e;

    typedef enum logic {
        lsu_idle,
        lsu_bus   // request on the bus, waiting for ack
    } lsu_state_e;

    // decoded instruction, driven combinationally from rv_decode
    typedef struct packed {
        op_class_e op_class;
        alu_op_e   alu_op;
        logic      use_imm;      // second operand is imm, not rs2
        word_t     imm;
        reg_idx_t  rd;
        logic [2:0] funct3;      // branch kind
        mem_size_e mem_size;
        logic      mem_unsigned; // zero-extend loads
    } dec_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        word_t     adr;
        byte_sel_t sel;
        word_t     dat;
    } wb_m2s_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

endpackage

/* rv_decode.sv */
// rv32i instruction decoder
module rv_decode (
    input  rv_pkg::word_t inst_i,
    output rv_pkg::dec_t  dec_o
);
    import rv_pkg::*;

    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    alu_op_e    base_op;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000); // sub / sra

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // funct3 mapping shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  base_op = alu_add;
            3'b001:  base_op = alu_sll;
            3'b010:  base_op = alu_slt;
            3'b011:  base_op = alu_sltu;
            3'b100:  base_op = alu_xor;
            3'b101:  base_op = f7_alt ? alu_sra : alu_srl;
            3'b110:  base_op = alu_or;
            default: base_op = alu_and;
        endcase
    end

    always_comb begin
        dec_o              = '0;
        dec_o.op_class     = cls_none;
        dec_o.alu_op       = base_op;
        dec_o.imm          = imm_i;
        dec_o.rd           = inst_i[11:7];
        dec_o.funct3       = funct3;
        dec_o.mem_unsigned = funct3[2];
        case (funct3[1:0])
            2'b00:   dec_o.mem_size = mem_byte;
            2'b01:   dec_o.mem_size = mem_half;
            default: dec_o.mem_size = mem_word;
        endcase

        case (opcode)
            opc_op_imm: begin
                dec_o.use_imm = 1'b1;
                if ((funct3 == 3'b001 && !f7_zero) ||
                    (funct3 == 3'b101 && !f7_zero && !f7_alt)) begin
                    dec_o.op_class = cls_none; // bad shift encoding
                end else begin
                    dec_o.op_class = cls_alu;
                end
            end
            opc_op: begin
                if (f7_zero) begin
                    dec_o.op_class = cls_alu;
                end else if (f7_alt && funct3 == 3'b000) begin
                    dec_o.op_class = cls_alu;
                    dec_o.alu_op   = alu_sub;
                end else if (f7_alt && funct3 == 3'b101) begin
                    dec_o.op_class = cls_alu;
                end // M extension falls through as none
            end
            opc_lui, opc_auipc: begin
                dec_o.op_class = cls_alu;
                dec_o.alu_op   = (opcode == opc_lui) ? alu_lui : alu_auipc;
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_u;
            end
            opc_branch: begin
                dec_o.imm = imm_b;
                if (funct3[2:1] != 2'b01) dec_o.op_class = cls_branch;
            end
            opc_jal: begin
                dec_o.op_class = cls_jal;
                dec_o.imm      = imm_j;
            end
            opc_jalr: begin
                if (funct3 == 3'b000) dec_o.op_class = cls_jalr;
            end
            opc_load: begin
                if (funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11) dec_o.op_class = cls_load;
            end
            opc_store: begin
                dec_o.imm = imm_s;
                if (!funct3[2] && funct3[1:0] != 2'b11) dec_o.op_class = cls_store;
            end
            default: dec_o.op_class = cls_none; // fence, system, custom
        endcase
    end

endmodule

/* rv_alu.sv */
// integer alu
module rv_alu (
    input  rv_pkg::dec_t  dec_i,
    input  rv_pkg::word_t pc_i,
    input  rv_pkg::word_t rs1_i,
    input  rv_pkg::word_t rs2_i,
    output rv_pkg::word_t result_o
);
    import rv_pkg::*;

    word_t      op2;
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign op2   = dec_i.use_imm ? dec_i.imm : rs2_i;
    assign shamt = op2[4:0]; // imm[4:0] or rs2[4:0]
    assign lt_s  = $signed(rs1_i) < $signed(op2);
    assign lt_u  = rs1_i < op2;

    always_comb begin
        case (dec_i.alu_op)
            alu_add: begin
                result_o = rs1_i + op2;
            end
            alu_sub: begin
                result_o = rs1_i - op2;
            end
            alu_sll: begin
                result_o = rs1_i << shamt;
            end
            alu_slt: begin
                result_o = {31'b0, lt_s};
            end
            alu_sltu: begin
                result_o = {31'b0, lt_u};
            end
            alu_xor: begin
                result_o = rs1_i ^ op2;
            end
            alu_srl: begin
                result_o = rs1_i >> shamt;
            end
            alu_sra: begin
                result_o = word_t'($signed(rs1_i) >>> shamt); // sign fill
            end
            alu_or: begin
                result_o = rs1_i | op2;
            end
            alu_and: begin
                result_o = rs1_i & op2;
            end
            alu_lui: begin
                result_o = dec_i.imm;
            end
            alu_auipc: begin
                result_o = pc_i + dec_i.imm;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* rv_branch_unit.sv */
// branch and jump resolution
module rv_branch_unit (
    input  rv_pkg::dec_t  dec_i,
    input  rv_pkg::word_t pc_i,
    input  rv_pkg::word_t rs1_i,
    input  rv_pkg::word_t rs2_i,
    output logic          take_o,
    output rv_pkg::word_t target_o,
    output rv_pkg::word_t link_o
);
    import rv_pkg::*;

    logic  eq;
    logic  lt;
    logic  ltu;
    logic  cond;
    word_t jalr_sum;

    assign eq  = (rs1_i == rs2_i);
    assign lt  = $signed(rs1_i) < $signed(rs2_i);
    assign ltu = rs1_i < rs2_i;

    always_comb begin
        case (dec_i.funct3)
            3'b000:  cond = eq;   // beq
            3'b001:  cond = !eq;  // bne
            3'b100:  cond = lt;   // blt
            3'b101:  cond = !lt;  // bge
            3'b110:  cond = ltu;  // bltu
            default: cond = !ltu; // bgeu
        endcase
    end

    always_comb begin
        case (dec_i.op_class)
            cls_branch:        take_o = cond;
            cls_jal, cls_jalr: take_o = 1'b1;
            default:           take_o = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_i + dec_i.imm;
    assign target_o = (dec_i.op_class == cls_jalr) ? {jalr_sum[31:1], 1'b0} : pc_i + dec_i.imm;
    assign link_o   = pc_i + 32'd4;

endmodule

/* rv_lsu.sv */
// load/store unit, wishbone classic master
module rv_lsu #(
    parameter int unsigned WB_ADDR_W = 16
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  rv_pkg::dec_t    dec_i,
    input  rv_pkg::word_t   rs1_i,
    input  rv_pkg::word_t   rs2_i,
    output logic            busy_o,
    output logic            done_o,
    output rv_pkg::word_t   load_data_o,
    output rv_pkg::wb_m2s_t wbm_o,
    input  rv_pkg::wb_s2m_t wbm_i
);
    import rv_pkg::*;

    lsu_state_e state_q;
    word_t      ea;
    byte_sel_t  sel_n;
    word_t      dat_n;
    logic       we_q;
    word_t      adr_q;
    byte_sel_t  sel_q;
    word_t      dat_q;
    logic [1:0] lane_q;
    mem_size_e  size_q;
    logic       unsigned_q;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;

    assign ea = rs1_i + dec_i.imm;

    // lane selects and store data replicated into every lane
    always_comb begin
        case (dec_i.mem_size)
            mem_byte: begin
                sel_n = 4'b0001 << ea[1:0];
                dat_n = {4{rs2_i[7:0]}};
            end
            mem_half: begin
                sel_n = ea[1] ? 4'b1100 : 4'b0011; // bit 0 ignored
                dat_n = {2{rs2_i[15:0]}};
            end
            default: begin
                sel_n = 4'b1111;
                dat_n = rs2_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= lsu_idle;
        end else begin
            case (state_q)
                lsu_idle: if (start_i) state_q <= lsu_bus;
                lsu_bus:  if (wbm_i.ack) state_q <= lsu_idle; // drop after ack
                default:  state_q <= lsu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == lsu_idle && start_i) begin
            we_q       <= (dec_i.op_class == cls_store);
            adr_q      <= word_t'(ea[WB_ADDR_W-1:2]) << 2; // word aligned, upper bits zero
            sel_q      <= sel_n;
            dat_q      <= dat_n;
            lane_q     <= ea[1:0];
            size_q     <= dec_i.mem_size;
            unsigned_q <= dec_i.mem_unsigned;
        end
    end

    assign busy_o = (state_q == lsu_bus);
    assign done_o = busy_o && wbm_i.ack;
    assign wbm_o  = '{cyc: busy_o, stb: busy_o, we: we_q, adr: adr_q, sel: sel_q, dat: dat_q};

    // lane pick and extension, valid in the ack cycle
    always_comb begin
        rd_byte = wbm_i.dat[8*lane_q +: 8];
        rd_half = lane_q[1] ? wbm_i.dat[31:16] : wbm_i.dat[15:0];
        case (size_q)
            mem_byte: begin
                load_data_o = unsigned_q ? {24'b0, rd_byte} : {{24{rd_byte[7]}}, rd_byte};
            end
            mem_half: begin
                load_data_o = unsigned_q ? {16'b0, rd_half} : {{16{rd_half[15]}}, rd_half};
            end
            default: begin
                load_data_o = wbm_i.dat;
            end
        endcase
    end

endmodule

/* rv_exec_unit.sv */
// rv32i execute and writeback stage
module rv_exec_unit #(
    parameter int unsigned WB_ADDR_W = 16
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             inst_valid_i,
    output logic             inst_ready_o,
    input  rv_pkg::word_t    inst_i,
    input  rv_pkg::word_t    pc_i,
    input  rv_pkg::word_t    rs1_data_i,
    input  rv_pkg::word_t    rs2_data_i,
    output logic             wb_valid_o,
    output rv_pkg::reg_idx_t wb_rd_o,
    output rv_pkg::word_t    wb_data_o,
    output logic             jump_o,
    output rv_pkg::word_t    jump_addr_o,
    output rv_pkg::wb_m2s_t  wbm_o,
    input  rv_pkg::wb_s2m_t  wbm_i
);
    import rv_pkg::*;

    dec_t  dec;
    word_t alu_result;
    word_t br_target;
    word_t br_link;
    word_t load_data;
    word_t result;
    logic  br_take;
    logic  lsu_busy;
    logic  lsu_done;
    logic  accept;
    logic  lsu_start;
    logic  writes_rd;

    rv_decode decode0 (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    rv_alu alu0 (
        .dec_i    (dec),
        .pc_i     (pc_i),
        .rs1_i    (rs1_data_i),
        .rs2_i    (rs2_data_i),
        .result_o (alu_result)
    );

    rv_branch_unit branch0 (
        .dec_i    (dec),
        .pc_i     (pc_i),
        .rs1_i    (rs1_data_i),
        .rs2_i    (rs2_data_i),
        .take_o   (br_take),
        .target_o (br_target),
        .link_o   (br_link)
    );

    rv_lsu #(
        .WB_ADDR_W (WB_ADDR_W)
    ) lsu0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (lsu_start),
        .dec_i       (dec),
        .rs1_i       (rs1_data_i),
        .rs2_i       (rs2_data_i),
        .busy_o      (lsu_busy),
        .done_o      (lsu_done),
        .load_data_o (load_data),
        .wbm_o       (wbm_o),
        .wbm_i       (wbm_i)
    );

    assign inst_ready_o = !lsu_busy;
    assign accept       = inst_valid_i && inst_ready_o;
    assign lsu_start    = accept && (dec.op_class inside {cls_load, cls_store});
    assign writes_rd    = dec.op_class inside {cls_alu, cls_jal, cls_jalr};

    always_comb begin
        case (dec.op_class)
            cls_jal, cls_jalr: result = br_link;
            cls_load:          result = load_data; // inputs held until ack
            default:           result = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            jump_o     <= 1'b0;
        end else begin
            wb_valid_o <= (accept && writes_rd) || (lsu_done && dec.op_class == cls_load);
            jump_o     <= accept && br_take;
        end
    end

    always_ff @(posedge clk) begin
        if (accept || lsu_done) begin
            wb_rd_o     <= dec.rd;
            wb_data_o   <= result;
            jump_addr_o <= br_target;
        end
    end

endmodule

/* tb_clk_gen.sv */
// testbench clock and reset
module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_o = 1'b1; // released away from the sampling edge
    end

endmodule

/* rv_exec_unit_sva.sv */
// execute stage handshake and bus assertions
module rv_exec_unit_sva (
    input logic            clk,
    input logic            rst_n_i,
    input logic            inst_ready_i,
    input logic            wb_valid_i,
    input rv_pkg::wb_m2s_t wbm_req_i,
    input rv_pkg::wb_s2m_t wbm_rsp_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0; // failed assertions so far

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
        wbm_req_i.stb |-> wbm_req_i.cyc)
        else begin
            $error("wishbone stb high without cyc");
            fail_count++;
        end

    // request frozen until the slave acks
    req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wbm_req_i.cyc && wbm_req_i.stb && !wbm_rsp_i.ack) |=>
        (wbm_req_i.cyc && wbm_req_i.stb &&
         $stable({wbm_req_i.we, wbm_req_i.adr, wbm_req_i.sel, wbm_req_i.dat})))
        else begin
            $error("wishbone request changed before ack");
            fail_count++;
        end

    drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wbm_req_i.cyc && wbm_rsp_i.ack) |=> !wbm_req_i.cyc)
        else begin
            $error("cyc still high after the acked transfer");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |=> !wb_valid_i)
        else begin
            $error("wb_valid_o high while in reset");
            fail_count++;
        end

    ready_blocked: assert property (@(posedge clk) disable iff (!rst_n_i)
        wbm_req_i.cyc |-> !inst_ready_i)
        else begin
            $error("inst_ready_o high during a bus cycle");
            fail_count++;
        end

endmodule

/* tb_rv_exec_unit.sv */
// execute stage testbench
module tb_rv_exec_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int clk_period = 4;
    localparam int max_cycles = 10; // per entry with the worst ack delay

    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    typedef struct packed {
        word_t    inst;
        word_t    pc;
        word_t    rs1;
        word_t    rs2;
        logic     wb;
        reg_idx_t rd;
        word_t    data;
        logic     jump;
        word_t    target;
    } test_t;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic        inst_ready;
    logic        wb_valid;
    logic        jump;
    word_t       inst;
    word_t       pc;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       wb_data;
    word_t       jump_addr;
    reg_idx_t    wb_rd;
    wb_m2s_t     wbm_req;
    wb_s2m_t     wbm_rsp;
    test_t       tests[$];
    logic        table_ready;
    word_t       mem [64];
    logic [31:0] lfsr;
    int unsigned wait_left;
    logic        in_access;

    tb_clk_gen #(.PERIOD_NS(clk_period), .RESET_CYCLES(4)) clkgen0 (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    rv_exec_unit #(.WB_ADDR_W(16)) dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_ready_o (inst_ready),
        .inst_i       (inst),
        .pc_i         (pc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data),
        .jump_o       (jump),
        .jump_addr_o  (jump_addr),
        .wbm_o        (wbm_req),
        .wbm_i        (wbm_rsp)
    );

    bind rv_exec_unit rv_exec_unit_sva sva0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_ready_i (inst_ready_o),
        .wb_valid_i   (wb_valid_o),
        .wbm_req_i    (wbm_o),
        .wbm_rsp_i    (wbm_i)
    );

    // rv32i encoders with rs1 = x1 and rs2 = x2
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task draw_delay(output int unsigned d);
        d = 0;
        repeat (2) begin // one step per bit
            lfsr = lfsr_next(lfsr);
            d    = (d << 1) | lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_entry(input word_t inst_v, input word_t pc_v, input word_t rs1_v,
                             input word_t rs2_v, input logic wb_v, input reg_idx_t rd_v,
                             input word_t data_v, input logic jump_v, input word_t target_v);
        tests.push_back('{inst_v, pc_v, rs1_v, rs2_v, wb_v, rd_v, data_v, jump_v, target_v});
    endtask

    // rows hold inst, pc, rs1, rs2, wb_valid, rd, data, jump and target
    task automatic build_table();
        // alu
        add_entry(i_type('hffb, 0, 3, opc_op_imm), 'h100, 10, 0, 1, 3, 5, 0, 0);
        add_entry(r_type('h00, 0, 4), 'h104, 'h7fff_ffff, 1, 1, 4, 'h8000_0000, 0, 0);
        add_entry(r_type('h20, 0, 5), 'h108, 3, 5, 1, 5, 'hffff_fffe, 0, 0);
        add_entry(r_type('h00, 2, 6), 'h10c, 'hffff_ffff, 1, 1, 6, 1, 0, 0); // slt
        add_entry(r_type('h00, 3, 7), 'h110, 'hffff_ffff, 1, 1, 7, 0, 0, 0); // sltu
        add_entry(r_type('h00, 1, 8), 'h114, 1, 'hffff_ffe4, 1, 8, 'h10, 0, 0);
        add_entry(r_type('h20, 5, 9), 'h118, 'h8000_0000, 4, 1, 9, 'hf800_0000, 0, 0);
        add_entry(r_type('h00, 5, 10), 'h11c, 'h8000_0000, 4, 1, 10, 'h0800_0000, 0, 0);
        add_entry(i_type('h408, 5, 11, opc_op_imm), 'h120, 'hff00_ff00, 0, 1, 11,
                  'hffff_00ff, 0, 0); // srai 8
        add_entry(i_type('h0ff, 4, 12, opc_op_imm), 'h124, 'hf0f0, 0, 1, 12, 'hf00f, 0, 0);
        add_entry(i_type('h800, 6, 13, opc_op_imm), 'h128, 'hf, 0, 1, 13, 'hffff_f80f, 0, 0);
        add_entry(i_type('h0f0, 7, 14, opc_op_imm), 'h12c, 'h1234_5678, 0, 1, 14, 'h70, 0, 0);
        add_entry(i_type('hfff, 2, 15, opc_op_imm), 'h130, 'hffff_fffe, 0, 1, 15, 1, 0, 0);
        add_entry(i_type('hfff, 3, 18, opc_op_imm), 'h134, 5, 0, 1, 18, 1, 0, 0);
        add_entry(u_type('h12345, 16, opc_lui), 'h138, 0, 0, 1, 16, 'h1234_5000, 0, 0);
        add_entry(u_type('h00001, 17, opc_auipc), 'h200, 0, 0, 1, 17, 'h1200, 0, 0);
        // each branch taken then not taken
        add_entry(b_type('h0010, 0), 'h400, 5, 5, 0, 0, 0, 1, 'h410);
        add_entry(b_type('h0010, 0), 'h400, 5, 6, 0, 0, 0, 0, 0);
        add_entry(b_type('h1ff8, 1), 'h400, 5, 6, 0, 0, 0, 1, 'h3f8);
        add_entry(b_type('h1ff8, 1), 'h400, 5, 5, 0, 0, 0, 0, 0);
        add_entry(b_type('h0010, 4), 'h400, 'hffff_ffff, 1, 0, 0, 0, 1, 'h410);
        add_entry(b_type('h0010, 4), 'h400, 1, 'hffff_ffff, 0, 0, 0, 0, 0);
        add_entry(b_type('h07fe, 5), 'h400, 1, 'hffff_ffff, 0, 0, 0, 1, 'hbfe);
        add_entry(b_type('h07fe, 5), 'h400, 'hffff_ffff, 1, 0, 0, 0, 0, 0);
        add_entry(b_type('h0800, 6), 'h400, 1, 'hffff_ffff, 0, 0, 0, 1, 'hc00);
        add_entry(b_type('h0800, 6), 'h400, 'hffff_ffff, 1, 0, 0, 0, 0, 0);
        add_entry(b_type('h1000, 7), 'h2400, 'hffff_ffff, 1, 0, 0, 0, 1, 'h1400);
        add_entry(b_type('h1000, 7), 'h2400, 1, 'hffff_ffff, 0, 0, 0, 0, 0);
        // jal and jalr
        add_entry(j_type('h012846, 1), 'h1000, 0, 0, 1, 1, 'h1004, 1, 'h13846);
        add_entry(j_type('h1ffffc, 5), 'h2000, 0, 0, 1, 5, 'h2004, 1, 'h1ffc);
        add_entry(i_type('h007, 0, 6, opc_jalr), 'h500, 'h3000, 0, 1, 6, 'h504, 1, 'h3006);
        add_entry(i_type('hffd, 0, 7, opc_jalr), 'h600, 'h3000, 0, 1, 7, 'h604, 1, 'h2ffc);
        // stores then loads over words filled with 8'h80 | n in each byte
        add_entry(i_type('h014, 2, 20, opc_load), 'h800, 0, 0, 1, 20, 'h8585_8585, 0, 0);
        add_entry(s_type('h000, 2), 'h804, 'h1234_0080, 'h1122_3344, 0, 0, 0, 0, 0);
        add_entry(i_type('h000, 2, 21, opc_load), 'h808, 'h80, 0, 1, 21, 'h1122_3344, 0, 0);
        add_entry(s_type('h001, 0), 'h80c, 'h80, 'haa, 0, 0, 0, 0, 0);
        add_entry(s_type('h004, 0), 'h810, 'h7f, 'h55, 0, 0, 0, 0, 0); // lane 3
        add_entry(i_type('h001, 0, 22, opc_load), 'h814, 'h80, 0, 1, 22, 'hffff_ffaa, 0, 0);
        add_entry(i_type('h001, 4, 23, opc_load), 'h818, 'h80, 0, 1, 23, 'haa, 0, 0);
        add_entry(i_type('h003, 0, 24, opc_load), 'h81c, 'h80, 0, 1, 24, 'h55, 0, 0);
        add_entry(s_type('h002, 1), 'h820, 'h84, 'hdead_8001, 0, 0, 0, 0, 0);
        add_entry(s_type('h000, 1), 'h824, 'h84, 'h1234_7ff0, 0, 0, 0, 0, 0);
        add_entry(i_type('h002, 1, 25, opc_load), 'h828, 'h84, 0, 1, 25, 'hffff_8001, 0, 0);
        add_entry(i_type('h002, 5, 26, opc_load), 'h82c, 'h84, 0, 1, 26, 'h8001, 0, 0);
        add_entry(i_type('h000, 1, 27, opc_load), 'h830, 'h84, 0, 1, 27, 'h7ff0, 0, 0);
        add_entry(i_type('h000, 2, 28, opc_load), 'h834, 'h84, 0, 1, 28, 'h8001_7ff0, 0, 0);
        add_entry(s_type('h000, 0), 'h838, 'h88, 'h01, 0, 0, 0, 0, 0);
        add_entry(s_type('hffe, 0), 'h83c, 'h8c, 'hfe, 0, 0, 0, 0, 0); // lane 2
        add_entry(i_type('h000, 2, 29, opc_load), 'h840, 'h88, 0, 1, 29, 'ha2fe_a201, 0, 0);
        add_entry(i_type('h002, 4, 30, opc_load), 'h844, 'h88, 0, 1, 30, 'hfe, 0, 0);
        add_entry(i_type('h000, 5, 19, opc_load), 'h848, 'h88, 0, 1, 19, 'ha201, 0, 0);
        // mul and fence retire silently
        add_entry(r_type('h01, 0, 3), 'h900, 6, 7, 0, 0, 0, 0, 0);
        add_entry('h0ff0_000f, 'h904, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic run_entry(input int i);
        test_t t;
        t          = tests[i];
        inst_valid = 1'b1;
        inst       = t.inst;
        pc         = t.pc;
        rs1_data   = t.rs1;
        rs2_data   = t.rs2;
        @(posedge clk); // accepted since ready was high
        @(negedge clk);
        while (!inst_ready) @(negedge clk); // held during the bus cycle
        check_value($sformatf("wb_valid_o [%0d]", i), t.wb, wb_valid);
        check_value($sformatf("jump_o [%0d]", i), t.jump, jump);
        if (t.wb) begin
            check_value($sformatf("wb_rd_o [%0d]", i), t.rd, wb_rd);
            check_value($sformatf("wb_data_o [%0d]", i), t.data, wb_data);
        end
        if (t.jump) begin
            check_value($sformatf("jump_addr_o [%0d]", i), t.target, jump_addr);
        end
    endtask

    task automatic serve_access();
        int idx;
        if (wbm_req.adr[31:8] != '0) begin
            $display("memory model: access at %h lies outside its 64 words", wbm_req.adr);
            $display("*** FAILED ***");
            $fatal(1, "bad bus address");
        end else begin
            idx = wbm_req.adr[7:2];
            if (wbm_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wbm_req.sel[b]) mem[idx][8*b +: 8] = wbm_req.dat[8*b +: 8];
                end
            end else begin
                wbm_rsp.dat <= mem[idx];
            end
            wbm_rsp.ack <= 1'b1;
        end
    endtask

    // wishbone memory with a random wait of 0 to 3 cycles before ack
    initial begin
        wbm_rsp   = '0;
        in_access = 1'b0;
        wait_left = 0;
        lfsr      = 32'd88338;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h8080_8080 | {4{2'b00, i[5:0]}};
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            wbm_rsp.ack <= 1'b0;
            in_access = 1'b0;
        end else if (wbm_rsp.ack) begin
            wbm_rsp.ack <= 1'b0;
            in_access = 1'b0;
        end else if (wbm_req.cyc && wbm_req.stb) begin
            if (!in_access) begin
                in_access = 1'b1;
                draw_delay(wait_left);
            end
            if (wait_left == 0) begin
                serve_access();
            end else begin
                wait_left--;
            end
        end
    end

    // any failed assertion in the bound checker ends the run
    initial begin
        wait (dut0.sva0.fail_count != 0);
        $display("an assertion on the handshake or the bus failed");
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first assertion failure");
    end

    // watchdog sized from the table once it exists
    initial begin
        wait (table_ready === 1'b1);
        #((8 + tests.size() * max_cycles) * clk_period);
        $display("timeout: the DUT stopped responding before the table was done");
        $display("*** FAILED ***");
        $fatal(1, "run ended by the watchdog");
    end

    initial begin
        inst_valid  = 1'b0;
        inst        = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("wb_valid_o after reset", 0, wb_valid);
        check_value("jump_o after reset", 0, jump);
        check_value("wbm_o.cyc after reset", 0, wbm_req.cyc);
        check_value("inst_ready_o after reset", 1, inst_ready);
        foreach (tests[i]) begin
            run_entry(i);
        end
        inst_valid = 1'b0;
        @(negedge clk);
        check_value("wb_valid_o when idle", 0, wb_valid);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* files.f */
rv_pkg.sv
rv_decode.sv
rv_alu.sv
rv_branch_unit.sv
rv_lsu.sv
rv_exec_unit.sv
tb_clk_gen.sv
rv_exec_unit_sva.sv
tb_rv_exec_unit.sv

/* Bender.yml */
package:
  name: rv_exec_unit

sources:
  - rv_pkg.sv
  - rv_decode.sv
  - rv_alu.sv
  - rv_branch_unit.sv
  - rv_lsu.sv
  - rv_exec_unit.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - rv_exec_unit_sva.sv
      - tb_rv_exec_unit.sv
